// File: logic/cachePkg.sv
package cachePkg;

  //////////////////////////////////////////////////
  // Cache geometry
  //////////////////////////////////////////////////
  localparam int tagBits   = 6;   // Tag field width
  localparam int setBits   = 6;   // Set index width
  localparam int wordBits  = 3;   // Word index inside a line
  localparam int numSets   = 64;  // Sets per way
  localparam int lineWords = 8;   // Words per line

  // AXI response code, the cache never reports an error
  localparam logic [1:0] respOkay = 2'b00;

  //////////////////////////////////////////////////
  // Shared structures
  //////////////////////////////////////////////////

  // Byte address split, MSB first
  typedef struct packed {
    logic [tagBits-1:0]  tag;      // Compared against the stored tag
    logic [setBits-1:0]  set;      // Selects one of 64 sets
    logic [wordBits-1:0] word;     // Word inside the 8-word line
    logic                byteSel;  // Ignored, all accesses are full words
  } addrT;

  // Metadata of one way in one set
  typedef struct packed {
    logic               valid;  // Line holds memory contents
    logic [tagBits-1:0] tag;    // Upper address bits of the cached line
  } metaT;

  // Request captured by the AXI front end
  typedef struct packed {
    logic        write;  // High for a write, low for a read
    addrT        addr;   // Word address of the access
    logic [15:0] wdata;  // Write data, unused on reads
  } cpuReqT;

  // Word request toward the backing memory
  typedef struct packed {
    logic        valid;  // Held until the memory acks
    logic        write;  // Write-through when high, line fill word when low
    addrT        addr;
    logic [15:0] data;
  } memReqT;

  // Memory completion, ack is a single cycle pulse
  typedef struct packed {
    logic        ack;
    logic [15:0] data;  // Read data, valid in the ack cycle
  } memRspT;

  // Outcome of one tag lookup
  typedef struct packed {
    logic           hit;        // Some way matched
    logic           hitWay;     // Matching way, meaningful on a hit
    logic           victimWay;  // Way to replace on a miss
    metaT [1:0]     meta;       // Raw metadata of both ways
  } lookupT;

endpackage

// File: logic/axiLiteFront.sv
module axiLiteFront import cachePkg::*; (
  input  logic        clk,
  input  logic        arstN,
  input  logic [15:0] awaddr,
  input  logic        awvalid,
  output logic        awready,
  input  logic [15:0] wdata,
  input  logic        wvalid,
  output logic        wready,
  output logic [1:0]  bresp,
  output logic        bvalid,
  input  logic        bready,
  input  logic [15:0] araddr,
  input  logic        arvalid,
  output logic        arready,
  output logic [15:0] rdata,
  output logic [1:0]  rresp,
  output logic        rvalid,
  input  logic        rready,
  output cpuReqT      req,        // Held stable while the engine works
  output logic        reqValid,   // Pulses once per accepted transaction
  input  logic        doneValid,  // Engine result strobe
  input  logic [15:0] doneData    // Read word from the engine
);

  typedef enum logic [1:0] {stIdle, stBusy, stResp} frontStateT;

  frontStateT state;
  frontStateT stateNext;
  logic       accept;     // Registered copy of the idle state, low out of reset
  logic       takeRd;     // AR handshake this cycle
  logic       takeWr;     // Joint AW and W handshake this cycle
  logic       respTaken;  // Master consumed the pending response

  //////////////////////////////////////////////////
  // Handshakes
  //////////////////////////////////////////////////
  assign arready = accept;
  // A write only transfers when both halves are present and no read competes
  assign awready = accept & ~arvalid & wvalid;
  assign wready  = accept & ~arvalid & awvalid;

  assign takeRd    = accept & arvalid;                        // Reads win a tie
  assign takeWr    = accept & ~arvalid & awvalid & wvalid;
  assign respTaken = (rvalid & rready) | (bvalid & bready);

  assign rresp = respOkay;  // No error path in this cache
  assign bresp = respOkay;

  // One transaction in flight at a time
  always_comb begin
    stateNext = state;
    case (state)
      stIdle:  if (takeRd | takeWr) stateNext = stBusy;
      stBusy:  if (doneValid) stateNext = stResp;
      stResp:  if (respTaken) stateNext = stIdle;  // Back-pressure parks us here
      default: stateNext = stIdle;
    endcase
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state    <= stIdle;
      accept   <= 1'b0;
      reqValid <= 1'b0;
      rvalid   <= 1'b0;
      bvalid   <= 1'b0;
    end else begin
      state    <= stateNext;
      accept   <= (stateNext == stIdle);  // Drops on the handshake edge itself
      reqValid <= takeRd | takeWr;
      if (state == stBusy && doneValid) begin
        rvalid <= ~req.write;  // Response kind follows the captured request
        bvalid <= req.write;
      end else if (respTaken) begin
        rvalid <= 1'b0;
        bvalid <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////
  // Request capture and read data register
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (takeRd) begin
      req.write <= 1'b0;
      req.addr  <= araddr;
      req.wdata <= '0;
    end else if (takeWr) begin
      req.write <= 1'b1;
      req.addr  <= awaddr;
      req.wdata <= wdata;
    end
    if (state == stBusy && doneValid) rdata <= doneData;  // Stable until taken
  end

endmodule

// File: logic/tagStore.sv
module tagStore import cachePkg::*; (
  input  logic               clk,
  input  logic               arstN,
  input  logic [setBits-1:0] lookupSet,  // Set to read and to update
  input  logic [tagBits-1:0] lookupTag,  // Tag of the current request
  output lookupT             result,     // Valid one cycle after lookupSet
  input  logic               metaWe,     // Write metaIn into metaWay
  input  logic               metaWay,
  input  metaT               metaIn,
  input  logic               lruWe,      // Update the set's LRU bit
  input  logic               lruVictim   // New victim way of the set
);

  metaT               metaArr [2][numSets];  // Way by set metadata
  logic [numSets-1:0] lruBits;               // One victim pointer per set
  metaT [1:0]         rdMeta;                // Both ways of the looked up set
  logic               rdLru;                 // LRU bit of the looked up set
  logic [tagBits-1:0] tagQ;                  // Request tag aligned with rdMeta
  logic               match0;
  logic               match1;

  //////////////////////////////////////////////////
  // Arrays, cleared so every line starts invalid
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int s = 0; s < numSets; s++) begin
        metaArr[0][s] <= '0;
        metaArr[1][s] <= '0;
      end
      lruBits <= '0;
    end else begin
      if (metaWe) metaArr[metaWay][lookupSet] <= metaIn;
      if (lruWe)  lruBits[lookupSet] <= lruVictim;
    end
  end

  // Registered read of both ways, done every cycle
  always_ff @(posedge clk) begin
    rdMeta[0] <= metaArr[0][lookupSet];
    rdMeta[1] <= metaArr[1][lookupSet];
    rdLru     <= lruBits[lookupSet];
    tagQ      <= lookupTag;  // Compare uses the tag from the same cycle
  end

  //////////////////////////////////////////////////
  // Parallel compare
  //////////////////////////////////////////////////
  assign match0 = rdMeta[0].valid && (rdMeta[0].tag == tagQ);
  assign match1 = rdMeta[1].valid && (rdMeta[1].tag == tagQ);

  always_comb begin
    result.hit    = match0 | match1;
    result.hitWay = match1;  // Only one way can match a given tag
    // Fill an empty way first, otherwise follow the LRU pointer
    if (!rdMeta[0].valid)      result.victimWay = 1'b0;
    else if (!rdMeta[1].valid) result.victimWay = 1'b1;
    else                       result.victimWay = rdLru;
    result.meta   = rdMeta;
  end

endmodule

// File: logic/dataStore.sv
module dataStore import cachePkg::*; (
  input  logic                clk,
  input  logic [setBits-1:0]  set,     // Set index of the access
  input  logic [wordBits-1:0] word,    // Word inside the line
  input  logic                we,      // Single word write
  input  logic                way,     // Way receiving the write
  input  logic [15:0]         wdata,
  output logic [15:0]         rdWay0,  // Registered read of way 0
  output logic [15:0]         rdWay1   // Registered read of way 1
);

  //////////////////////////////////////////////////
  // Storage, 512 words per way
  //////////////////////////////////////////////////
  logic [15:0]                 mem [2][numSets*lineWords];
  logic [setBits+wordBits-1:0] idx;  // Flat word index inside a way

  // Set and word concatenate into the row address
  assign idx = {set, word};

  // Both ways are read each cycle so the hit way can be picked afterwards
  always_ff @(posedge clk) begin
    if (we) begin
      mem[way][idx] <= wdata;  // Read below still returns the old word
    end
    rdWay0 <= mem[0][idx];
    rdWay1 <= mem[1][idx];
  end

endmodule

// File: logic/missEngine.sv
module missEngine import cachePkg::*; (
  input  logic                clk,
  input  logic                arstN,
  input  cpuReqT              req,        // Stable from reqValid until done
  input  logic                reqValid,
  output logic                doneValid,
  output logic [15:0]         doneData,
  output logic [setBits-1:0]  lookupSet,
  output logic [tagBits-1:0]  lookupTag,
  input  lookupT              lookup,
  output logic                metaWe,
  output logic                metaWay,
  output metaT                metaIn,
  output logic                lruWe,
  output logic                lruVictim,
  output logic [setBits-1:0]  dataSet,
  output logic [wordBits-1:0] dataWord,
  output logic                dataWe,
  output logic                dataWay,
  output logic [15:0]         dataWdata,
  input  logic [15:0]         rdWay0,
  input  logic [15:0]         rdWay1,
  output memReqT              memReq,
  input  memRspT              memRsp
);

  typedef enum logic [2:0] {
    stIdle, stLookup, stWriteThru, stFill, stFillRead, stDone
  } engStateT;

  engStateT            state;
  logic [wordBits-1:0] fillCnt;  // Next line word to fetch
  logic                wayQ;     // Hit way, or victim way during a fill
  logic                lastWord;

  assign lastWord = (fillCnt == wordBits'(lineWords - 1));
  // Read result comes straight from the registered array output
  assign doneData = wayQ ? rdWay1 : rdWay0;

  //////////////////////////////////////////////////
  // Datapath control
  //////////////////////////////////////////////////
  always_comb begin
    lookupSet   = req.addr.set;   // Arrays always follow the request
    lookupTag   = req.addr.tag;
    dataSet     = req.addr.set;
    dataWord    = req.addr.word;
    dataWe      = 1'b0;
    dataWay     = wayQ;
    dataWdata   = req.wdata;
    metaWe      = 1'b0;
    metaWay     = wayQ;
    metaIn      = '{valid: 1'b1, tag: req.addr.tag};
    lruWe       = 1'b0;
    lruVictim   = ~wayQ;          // The other way becomes the victim
    memReq      = '0;
    memReq.write = req.write;
    memReq.addr  = req.addr;
    memReq.data  = req.wdata;
    doneValid   = 1'b0;
    case (state)
      stLookup: begin
        if (lookup.hit) begin
          lruWe     = 1'b1;
          lruVictim = ~lookup.hitWay;
          dataWay   = lookup.hitWay;
          dataWe    = req.write;  // Write hit updates the cached copy too
        end
      end
      stWriteThru: begin
        memReq.valid = 1'b1;
        doneValid    = memRsp.ack;  // So bvalid follows the ack by one cycle
      end
      stFill: begin
        memReq.valid        = 1'b1;
        memReq.write        = 1'b0;
        memReq.addr.word    = fillCnt;
        memReq.addr.byteSel = 1'b0;
        dataWord            = fillCnt;
        dataWdata           = memRsp.data;
        dataWe              = memRsp.ack;
        metaWe              = memRsp.ack & lastWord;  // Line turns valid with its last word
        lruWe               = memRsp.ack & lastWord;
      end
      stDone:  doneValid = 1'b1;
      default: ;
    endcase
  end

  //////////////////////////////////////////////////
  // State sequencing
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state   <= stIdle;
      fillCnt <= '0;
      wayQ    <= 1'b0;
    end else begin
      case (state)
        stIdle: if (reqValid) state <= stLookup;  // Arrays are read on this edge
        stLookup: begin
          if (lookup.hit) begin
            wayQ  <= lookup.hitWay;
            state <= req.write ? stWriteThru : stDone;
          end else if (req.write) begin
            state <= stWriteThru;  // No write-allocate, tags stay as they are
          end else begin
            wayQ    <= lookup.victimWay;
            fillCnt <= '0;
            state   <= stFill;
          end
        end
        stWriteThru: if (memRsp.ack) state <= stIdle;
        stFill: begin
          if (memRsp.ack) begin
            fillCnt <= fillCnt + 1'b1;
            if (lastWord) state <= stFillRead;
          end
        end
        stFillRead: state <= stDone;  // Reread the requested word from the new line
        stDone:     state <= stIdle;
        default:    state <= stIdle;
      endcase
    end
  end

endmodule

// File: logic/cacheTop.sv
module cacheTop import cachePkg::*; (
  input  logic        clk,      // System clock
  input  logic        arstN,    // Asynchronous reset, active low
  // AXI4-Lite write address and data
  input  logic [15:0] awaddr,
  input  logic        awvalid,
  output logic        awready,
  input  logic [15:0] wdata,
  input  logic        wvalid,
  output logic        wready,
  // AXI4-Lite write response
  output logic [1:0]  bresp,
  output logic        bvalid,
  input  logic        bready,
  // AXI4-Lite read address and data
  input  logic [15:0] araddr,
  input  logic        arvalid,
  output logic        arready,
  output logic [15:0] rdata,
  output logic [1:0]  rresp,
  output logic        rvalid,
  input  logic        rready,
  // Backing memory port
  output memReqT      memReq,
  input  memRspT      memRsp
);

  //////////////////////////////////////////////////
  // Internal wiring
  //////////////////////////////////////////////////
  cpuReqT              req;         // Captured CPU request
  logic                reqValid;    // One cycle start pulse
  logic                doneValid;   // Engine finished the request
  logic [15:0]         doneData;    // Read result for the front end
  logic [setBits-1:0]  lookupSet;
  logic [tagBits-1:0]  lookupTag;
  lookupT              lookup;      // Tag compare result
  logic                metaWe;
  logic                metaWay;
  metaT                metaIn;
  logic                lruWe;
  logic                lruVictim;
  logic [setBits-1:0]  dataSet;
  logic [wordBits-1:0] dataWord;
  logic                dataWe;
  logic                dataWay;
  logic [15:0]         dataWdata;
  logic [15:0]         rdWay0;      // Registered word of way 0
  logic [15:0]         rdWay1;      // Registered word of way 1

  // CPU facing AXI4-Lite slave
  axiLiteFront u_axiLiteFront (
    .clk(clk), .arstN(arstN),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
    .req(req), .reqValid(reqValid), .doneValid(doneValid), .doneData(doneData)
  );

  tagStore u_tagStore (
    .clk(clk), .arstN(arstN),
    .lookupSet(lookupSet), .lookupTag(lookupTag), .result(lookup),
    .metaWe(metaWe), .metaWay(metaWay), .metaIn(metaIn),
    .lruWe(lruWe), .lruVictim(lruVictim)
  );

  dataStore u_dataStore (
    .clk(clk), .set(dataSet), .word(dataWord), .we(dataWe), .way(dataWay),
    .wdata(dataWdata), .rdWay0(rdWay0), .rdWay1(rdWay1)
  );

  // Sequencing of lookups, fills and write-through
  missEngine u_missEngine (
    .clk(clk), .arstN(arstN),
    .req(req), .reqValid(reqValid), .doneValid(doneValid), .doneData(doneData),
    .lookupSet(lookupSet), .lookupTag(lookupTag), .lookup(lookup),
    .metaWe(metaWe), .metaWay(metaWay), .metaIn(metaIn),
    .lruWe(lruWe), .lruVictim(lruVictim),
    .dataSet(dataSet), .dataWord(dataWord), .dataWe(dataWe), .dataWay(dataWay),
    .dataWdata(dataWdata), .rdWay0(rdWay0), .rdWay1(rdWay1),
    .memReq(memReq), .memRsp(memRsp)
  );

endmodule

// File: dv/tbClock.sv
module tbClock (
  output logic clk  // Free running, 100 time units per period
);

  initial clk = 1'b0;

  always #50 clk = ~clk;  // Half period

endmodule

// File: dv/cacheTb.sv
module cacheTb import cachePkg::*; ();

  logic        clk;
  logic        arstN;
  logic [15:0] awaddr;
  logic        awvalid;
  logic        awready;
  logic [15:0] wdata;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  logic [15:0] araddr;
  logic        arvalid;
  logic        arready;
  logic [15:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        rready;
  memReqT      memReq;
  memRspT      memRsp;

  logic [15:0] memWords [32768];  // Backing memory indexed by word address
  logic [14:0] readLog [$];       // Word addresses read since the last clear
  int          memReads;
  int          memWrites;
  int          ackWait;           // Cycles left before the pending ack
  integer      seed;

  tbClock u_tbClock (.clk(clk));

  cacheTop u_cacheTop (.*);

  //////////////////////////////////////////////////
  // Memory model
  //////////////////////////////////////////////////
  initial begin
    seed      = 50420;
    memRsp    = '0;
    ackWait   = 0;
    memReads  = 0;
    memWrites = 0;
    for (int i = 0; i < 32768; i++) begin
      memWords[i] = 16'(i * 7) ^ 16'h5A3C;  // Odd multiplier keeps every word distinct
    end
  end

  // Ack comes 1 to 4 cycles after a request is first seen
  always @(negedge clk) begin
    if (memRsp.ack) begin
      memRsp = '0;  // Ack lasts one cycle and the next request is looked at a cycle later
    end else if (memReq.valid) begin
      if (ackWait == 0) ackWait = 1 + ($unsigned($random(seed)) % 4);
      ackWait--;
      if (ackWait == 0) begin
        if (memReq.write) begin
          memWords[memReq.addr[15:1]] = memReq.data;
          memWrites++;
        end else begin
          memRsp.data = memWords[memReq.addr[15:1]];
          readLog.push_back(memReq.addr[15:1]);
          memReads++;
        end
        memRsp.ack = 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////
  task automatic abortRun();
    $display("TB FAILED");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic checkEq(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Mismatch at time %0t: %s is %0h, expected %0h",
               $time, name, actual, expected);
      abortRun();
    end
  endtask

  // Byte address from tag, set and word index
  function automatic logic [15:0] mkAddr(input int tag, input int set, input int word);
    return {6'(tag), 6'(set), 3'(word), 1'b0};
  endfunction

  function automatic logic sigNow(input int which);
    case (which)
      0:       return arready;
      1:       return awready && wready;  // Write address and data go together
      2:       return rvalid;
      default: return bvalid;
    endcase
  endfunction

  // Polls just after the falling edge, when every output has settled
  task automatic waitHigh(input int which, input string name, output int cycles);
    cycles = 0;
    #1;
    while (!sigNow(which)) begin
      @(negedge clk);
      #1;
      cycles++;
      if (cycles > 300) begin
        $display("Timeout at time %0t: %s never came", $time, name);
        abortRun();
      end
    end
  endtask

  task automatic clearCounts();
    memReads  = 0;
    memWrites = 0;
    readLog.delete();
  endtask

  // Returns the cycles from the AR handshake to rvalid
  task automatic readWord(input logic [15:0] addr, output logic [15:0] data, output int lat);
    araddr  = addr;
    arvalid = 1'b1;
    waitHigh(0, "arready", lat);
    @(negedge clk);
    arvalid = 1'b0;
    waitHigh(2, "rvalid", lat);
    checkEq("rresp", rresp, 2'b00);
    data = rdata;
    if (rready) @(negedge clk);  // Response is taken at the next rising edge
  endtask

  task automatic writeWord(input logic [15:0] addr, input logic [15:0] data);
    int cycles;
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    waitHigh(1, "awready and wready", cycles);
    @(negedge clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    waitHigh(3, "bvalid", cycles);
    checkEq("bresp", bresp, 2'b00);
    if (bready) @(negedge clk);
  endtask

  // A fill must fetch words 0 to 7 of the requested line in order
  task automatic readCheck(input logic [15:0] addr, input logic [15:0] exp,
                           input int expReads, output int lat);
    logic [15:0] data;
    clearCounts();
    readWord(addr, data, lat);
    checkEq("rdata", data, exp);
    checkEq("memory reads", memReads, expReads);
    checkEq("memory writes", memWrites, 0);
    for (int i = 0; i < memReads; i++) begin
      checkEq("fill address", readLog[i], {addr[15:4], 3'(i)});
    end
  endtask

  task automatic writeCheck(input logic [15:0] addr, input logic [15:0] data);
    clearCounts();
    writeWord(addr, data);
    checkEq("memory writes", memWrites, 1);  // Exactly one write-through
    checkEq("memory reads", memReads, 0);    // No allocate on a write
    checkEq("memory word", memWords[addr[15:1]], data);
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////

  // Runs while reset is still applied so no clock edge can hide a wrong reset value
  task automatic testReset();
    checkEq("arready", arready, 0);
    checkEq("awready", awready, 0);
    checkEq("wready", wready, 0);
    checkEq("rvalid", rvalid, 0);
    checkEq("bvalid", bvalid, 0);
    checkEq("memReq.valid", memReq.valid, 0);
  endtask

  task automatic testReadMissHit();
    int lat;
    readCheck(mkAddr(5, 10, 3), memWords[mkAddr(5, 10, 3) >> 1], 8, lat);
    readCheck(mkAddr(5, 10, 6), memWords[mkAddr(5, 10, 6) >> 1], 0, lat);  // Same line
    checkEq("read hit latency", lat, 3);
  endtask

  task automatic testWriteHit();
    int lat;
    writeCheck(mkAddr(5, 10, 3), 16'hBEEF);
    readCheck(mkAddr(5, 10, 3), 16'hBEEF, 0, lat);  // Cached copy was updated too
  endtask

  task automatic testWriteMiss();
    int lat;
    writeCheck(mkAddr(9, 20, 2), 16'h1357);
    readCheck(mkAddr(9, 20, 2), 16'h1357, 8, lat);  // Line was never allocated
  endtask

  // Tags 1, 2 and 3 share set 33, so the A hit leaves B as the victim for C
  task automatic testLru();
    int lat;
    readCheck(mkAddr(1, 33, 4), memWords[mkAddr(1, 33, 4) >> 1], 8, lat);
    readCheck(mkAddr(2, 33, 4), memWords[mkAddr(2, 33, 4) >> 1], 8, lat);
    readCheck(mkAddr(1, 33, 4), memWords[mkAddr(1, 33, 4) >> 1], 0, lat);
    readCheck(mkAddr(3, 33, 4), memWords[mkAddr(3, 33, 4) >> 1], 8, lat);
    readCheck(mkAddr(1, 33, 4), memWords[mkAddr(1, 33, 4) >> 1], 0, lat);
    readCheck(mkAddr(2, 33, 4), memWords[mkAddr(2, 33, 4) >> 1], 8, lat);
  endtask

  task automatic testBackPressure();
    logic [15:0] data;
    int          lat;
    rready = 1'b0;
    readWord(mkAddr(5, 10, 3), data, lat);
    checkEq("rdata", data, 16'hBEEF);
    repeat (4) begin
      @(negedge clk);
      araddr  = mkAddr(5, 10, 6);
      arvalid = 1'b1;  // Second read waits until the first response is gone
      checkEq("rvalid", rvalid, 1);
      checkEq("rdata", rdata, data);
      checkEq("arready", arready, 0);
    end
    rready = 1'b1;
    readCheck(mkAddr(5, 10, 6), memWords[mkAddr(5, 10, 6) >> 1], 0, lat);
    bready = 1'b0;
    writeWord(mkAddr(5, 10, 6), 16'h2468);
    repeat (4) begin
      @(negedge clk);
      checkEq("bvalid", bvalid, 1);
      checkEq("arready", arready, 0);
    end
    bready = 1'b1;
    @(negedge clk);
    checkEq("bvalid", bvalid, 0);
    checkEq("memory word", memWords[mkAddr(5, 10, 6) >> 1], 16'h2468);
  endtask

  //////////////////////////////////////////////////
  // Sequence
  //////////////////////////////////////////////////
  initial begin
    arstN   = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wvalid  = 1'b0;
    bready  = 1'b1;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b1;
    repeat (2) @(negedge clk);  // Two rising edges inside reset
    testReset();
    arstN = 1'b1;
    @(negedge clk);
    testReadMissHit();
    testWriteHit();
    testWriteMiss();
    testLru();
    testBackPressure();
    $display("TB PASSED");
    $finish;
  end

endmodule

// File: src.f
logic/cachePkg.sv
logic/axiLiteFront.sv
logic/tagStore.sv
logic/dataStore.sv
logic/missEngine.sv
logic/cacheTop.sv
dv/tbClock.sv
dv/cacheTb.sv
